//--- project.f
source/piano_pkg.sv
source/key_capture.sv
source/beat_timer.sv
source/song_lookup.sv
source/note_judge.sv
source/led_feedback.sv
source/piano_trainer_top.sv
dv/piano_trainer_props.sv
dv/piano_trainer_tb.sv

//--- dv/piano_stim.txt
// One press per line as four hex digits
// Digits are key, beats to wait, expected note_ok and expected timing_ok
// Beats are counted from reset for the first press
// and from the end of the previous handshake after that

// Song steps 0 to 3
1111
3211
// Wrong note on time
4101
// One beat early is still in time
6111

// Steps 4 to 7
// Early press
8110
// Zero beats against a one beat duration
A011
// Late press
C610
A211

// Steps 8 to 11
// Wrong note and late
9300
6211
// Very late
5F10
// Last step ends the song
1411

// After the song end, acknowledged without a result
7200
// Zero key
0100

//--- dv/piano_trainer_tb.sv
// Testbench for the piano practice core with stim file presses and result, score and LED checks
`timescale 1ns/100ps
`default_nettype none

module piano_trainer_tb;

    localparam int STIM_LINES = 14;
    localparam int CLK_HALF   = 20;
    // Worst case per press is 15 beats plus the handshake
    localparam int MAX_CYCLES = STIM_LINES * (15 * piano_pkg::BEAT_CYCLES + 10)
                                + piano_pkg::FEEDBACK_CYCLES + 40;

    logic                           clock;
    logic                           rst_n;
    logic                           key_req;
    piano_pkg::note_t               key;
    logic                           key_ack;
    logic                           beat;
    piano_pkg::result_s             result;
    logic [3:0]                     score;
    logic                           song_done;
    logic [piano_pkg::NUM_LEDS-1:0] leds;

    logic [15:0]                    stim_mem [STIM_LINES];
    int                             cycles;
    int                             checks;
    int                             value_errors;
    int                             other_errors;

    // Reference model state
    int                             step_exp;
    logic [3:0]                     score_exp;
    logic                           done_exp;
    logic [piano_pkg::NUM_LEDS-1:0] led_exp;
    int                             led_left;
    logic                           led_load;
    piano_pkg::note_t               led_key;
    int                             beat_phase;

    piano_trainer_top piano_trainer_top_inst (
        .clock     ( clock     ),
        .rst_n     ( rst_n     ),
        .key_req   ( key_req   ),
        .key       ( key       ),
        .key_ack   ( key_ack   ),
        .beat      ( beat      ),
        .result    ( result    ),
        .score     ( score     ),
        .song_done ( song_done ),
        .leds      ( leds      )
    );

    initial begin
        clock = 1'b0;
        forever #CLK_HALF clock = ~clock;
    end

    task automatic report_counts();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clock);
            cycles = cycles + 1;
        end
        $display("Timeout, the run did not end within %0d cycles", MAX_CYCLES);
        report_counts();
        $display("sim failed");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            value_errors = value_errors + 1;
            $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Falling edge step with the beat and LED models
    task automatic next_cycle();
        @(negedge clock);
        // Metronome phase counts every edge after reset
        if (rst_n) begin
            beat_phase = (beat_phase + 1) % piano_pkg::BEAT_CYCLES;
        end
        if (led_load) begin
            // Lit in the result cycle and for the feedback time after it
            led_exp          = '0;
            led_exp[led_key - 1] = 1'b1;
            led_left         = piano_pkg::FEEDBACK_CYCLES + 1;
            led_load         = 1'b0;
        end else if (led_left != 0) begin
            led_left = led_left - 1;
            if (led_left == 0) begin
                led_exp = '0;
            end
        end
        compare_value("beat", beat, beat_phase == piano_pkg::BEAT_CYCLES - 1);
        compare_value("leds", leds, led_exp);
    endtask

    task automatic wait_beats(input int count);
        int seen;
        seen = 0;
        while (seen < count) begin
            next_cycle();
            if (beat) begin
                seen = seen + 1;
            end
        end
        // Press goes out on the falling edge after the counted beat edge
        if (count > 0) begin
            next_cycle();
        end
    endtask

    task automatic press_key(input piano_pkg::note_t note, input logic note_ok_exp,
                             input logic timing_ok_exp);
        int   i;
        int   ack_at;
        logic ack_up;
        logic ack_down;
        logic failed;
        logic has_result;
        logic scores;
        logic last;
        has_result = (note != 4'd0) && (step_exp < piano_pkg::SONG_LEN);
        scores     = has_result && note_ok_exp && timing_ok_exp;
        last       = has_result && (step_exp == piano_pkg::SONG_LEN - 1);
        i          = 0;
        ack_at     = 0;
        ack_up     = 1'b0;
        ack_down   = 1'b0;
        failed     = 1'b0;
        key_req    = 1'b1;
        key        = note;
        while (!failed && (!ack_down || i < 5)) begin
            // The LED lights in the same cycle as the result
            if (has_result && (i == 3)) begin
                led_load = 1'b1;
                led_key  = note;
            end
            next_cycle();
            i = i + 1;
            if (!ack_up) begin
                if (key_ack) begin
                    ack_up  = 1'b1;
                    ack_at  = i;
                    key_req = 1'b0;
                    key     = '0;
                end else if (i >= 4) begin
                    other_errors = other_errors + 1;
                    $display("key_ack did not rise within 4 cycles for key 0x%0h", note);
                    key_req = 1'b0;
                    failed  = 1'b1;
                end
            end else if (!ack_down) begin
                if (!key_ack) begin
                    ack_down = 1'b1;
                end else if (i - ack_at >= 4) begin
                    other_errors = other_errors + 1;
                    $display("key_ack did not fall within 4 cycles after key_req dropped");
                    failed = 1'b1;
                end
            end
            // Result is due 3 cycles after the edge that samples key_req
            compare_value("result.valid", result.valid, has_result && (i == 4));
            if (has_result && (i == 4)) begin
                compare_value("result.step", result.step, step_exp);
                compare_value("result.key", result.key, note);
                compare_value("result.note_ok", result.note_ok, note_ok_exp);
                compare_value("result.timing_ok", result.timing_ok, timing_ok_exp);
            end
            compare_value("score", score, score_exp + ((scores && i >= 4) ? 1 : 0));
            compare_value("song_done", song_done, done_exp || (last && i >= 4));
        end
        if (scores) begin
            score_exp = score_exp + 4'd1;
        end
        if (last) begin
            done_exp = 1'b1;
        end
        if (has_result) begin
            step_exp = step_exp + 1;
        end
    endtask

    initial begin
        piano_pkg::note_t note;
        int               wait_cnt;
        rst_n        = 1'b0;
        key_req      = 1'b0;
        key          = '0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        step_exp     = 0;
        score_exp    = 4'd0;
        done_exp     = 1'b0;
        led_exp      = '0;
        led_left     = 0;
        led_load     = 1'b0;
        led_key      = '0;
        beat_phase   = 0;
        $readmemh("dv/piano_stim.txt", stim_mem);
        repeat (2) next_cycle();
        rst_n = 1'b1;
        if ($isunknown(stim_mem[0]) || $isunknown(stim_mem[STIM_LINES-1])) begin
            other_errors = other_errors + 1;
            $display("Stim file dv/piano_stim.txt could not be read completely");
        end else begin
            for (int line = 0; line < STIM_LINES; line++) begin
                note     = stim_mem[line][15:12];
                wait_cnt = stim_mem[line][11:8];
                wait_beats(wait_cnt);
                press_key(note, stim_mem[line][4], stim_mem[line][0]);
            end
            // Let the last feedback window run out
            repeat (piano_pkg::FEEDBACK_CYCLES + 4) next_cycle();
            compare_value("leds", leds, '0);
            compare_value("score", score, score_exp);
            compare_value("song_done", song_done, done_exp);
        end
        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/piano_trainer_props.sv
// Bound concurrent assertions on the key handshake, result issue, score and song end
`timescale 1ns/100ps
`default_nettype none

module piano_trainer_props (
    input wire logic       clock,
    input wire logic       rst_n,
    input wire logic       key_req,
    input wire logic       key_ack,
    input wire logic       result_valid,
    input wire logic [3:0] score,
    input wire logic       song_done
);

    // Ack only goes up for a request that is present
    ack_rise_with_req: assert property (
        @(posedge clock) disable iff (!rst_n)
        $rose(key_ack) |-> $past(key_req)
    ) else $error("key_ack rose while key_req was low");

    ack_hold_with_req: assert property (
        @(posedge clock) disable iff (!rst_n)
        $fell(key_ack) |-> !$past(key_req)
    ) else $error("key_ack fell while key_req was high");

    // The last result and song_done arrive together, nothing follows
    no_result_after_done: assert property (
        @(posedge clock) disable iff (!rst_n)
        $past(song_done) |-> !result_valid
    ) else $error("result valid after song_done");

    score_monotonic: assert property (
        @(posedge clock) disable iff (!rst_n)
        score >= $past(score)
    ) else $error("score decreased");

endmodule

// Unused inputs of each instance are tied off
bind key_capture piano_trainer_props key_props_inst (
    .clock        ( clock   ),
    .rst_n        ( rst_n   ),
    .key_req      ( key_req ),
    .key_ack      ( key_ack ),
    .result_valid ( 1'b0    ),
    .score        ( 4'd0    ),
    .song_done    ( 1'b0    )
);

bind note_judge piano_trainer_props judge_props_inst (
    .clock        ( clock        ),
    .rst_n        ( rst_n        ),
    .key_req      ( 1'b0         ),
    .key_ack      ( 1'b0         ),
    .result_valid ( result.valid ),
    .score        ( score        ),
    .song_done    ( song_done    )
);

`default_nettype wire

//--- source/piano_trainer_top.sv
// Top level of the piano practice core connecting capture, timer, lookup, judge and LEDs
`timescale 1ns/100ps
`default_nettype none

module piano_trainer_top (
    input  wire logic                         clock,
    input  wire logic                         rst_n,
    input  wire logic                         key_req,
    input  wire piano_pkg::note_t             key,
    output logic                              key_ack,
    output logic                              beat,
    output piano_pkg::result_s                result,
    output logic [3:0]                        score,
    output logic                              song_done,
    output logic [piano_pkg::NUM_LEDS-1:0]    leds
);

    logic                 beat_clear;
    logic [3:0]           elapsed;
    piano_pkg::capture_s  cap;
    piano_pkg::lookup_s   look;

    // Four-phase key entry
    key_capture key_capture_inst (
        .clock      ( clock      ),
        .rst_n      ( rst_n      ),
        .key_req    ( key_req    ),
        .key        ( key        ),
        .elapsed    ( elapsed    ),
        .key_ack    ( key_ack    ),
        .beat_clear ( beat_clear ),
        .cap        ( cap        )
    );

    // Metronome and beats since the last press
    beat_timer beat_timer_inst (
        .clock      ( clock      ),
        .rst_n      ( rst_n      ),
        .beat_clear ( beat_clear ),
        .beat       ( beat       ),
        .elapsed    ( elapsed    )
    );

    song_lookup song_lookup_inst (
        .clock ( clock ),
        .rst_n ( rst_n ),
        .cap   ( cap   ),
        .look  ( look  )
    );

    note_judge note_judge_inst (
        .clock     ( clock     ),
        .rst_n     ( rst_n     ),
        .look      ( look      ),
        .result    ( result    ),
        .score     ( score     ),
        .song_done ( song_done )
    );

    // LEDs follow the judged key
    led_feedback led_feedback_inst (
        .clock  ( clock  ),
        .rst_n  ( rst_n  ),
        .result ( result ),
        .leds   ( leds   )
    );

endmodule

`default_nettype wire

//--- source/led_feedback.sv
// One-hot note LED driver held for the feedback time
`timescale 1ns/100ps
`default_nettype none

module led_feedback (
    input  wire logic                         clock,
    input  wire logic                         rst_n,
    input  wire piano_pkg::result_s           result,
    output logic [piano_pkg::NUM_LEDS-1:0]    leds
);

    logic [piano_pkg::FEEDBACK_W-1:0] hold_cnt;
    logic [piano_pkg::NUM_LEDS-1:0]   key_led;
    logic [piano_pkg::NUM_LEDS-1:0]   lit;

    assign key_led = piano_pkg::NUM_LEDS'(1) << (result.key - 4'd1);

    // The judged key lights together with its result and then stays lit from the register
    assign leds = result.valid ? key_led : lit;

    // A new result always restarts the feedback window
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            lit      <= '0;
            hold_cnt <= '0;
        end else if (result.valid) begin
            lit      <= key_led;
            hold_cnt <= piano_pkg::FEEDBACK_W'(piano_pkg::FEEDBACK_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
            // Dark as the count hits zero
            if (hold_cnt == piano_pkg::FEEDBACK_W'(1)) begin
                lit <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/note_judge.sv
// Note and timing judge with score counter and song end flag
`timescale 1ns/100ps
`default_nettype none

module note_judge (
    input  wire logic                clock,
    input  wire logic                rst_n,
    input  wire piano_pkg::lookup_s  look,
    output piano_pkg::result_s       result,
    output logic [3:0]               score,
    output logic                     song_done
);

    logic note_match;
    logic time_match;
    logic last_step;

    // Timing is accepted on the stored duration or one beat early
    always_comb begin
        note_match = (look.key == look.expected);
        time_match = (look.elapsed == look.duration) ||
                     (look.elapsed == (look.duration - 4'd1));
    end

    assign last_step = (look.step == piano_pkg::step_t'(piano_pkg::SONG_LEN - 1));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= look.valid;
        end
    end

    always_ff @(posedge clock) begin
        result.step      <= look.step;
        result.key       <= look.key;
        result.note_ok   <= note_match;
        result.timing_ok <= time_match;
    end

    // Only a right note played in time earns a point
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            score <= 4'd0;
        end else if (look.valid && note_match && time_match) begin
            score <= score + 4'd1;
        end
    end

    // Sticky until reset, rises together with the last result
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            song_done <= 1'b0;
        end else if (look.valid && last_step) begin
            song_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/song_lookup.sv
// Song step counter and song table read stage
`timescale 1ns/100ps
`default_nettype none

module song_lookup (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire piano_pkg::capture_s  cap,
    output piano_pkg::lookup_s        look
);

    piano_pkg::step_t step;
    logic             song_left;

    // Steps remain until the whole song was played
    assign song_left = (step != piano_pkg::step_t'(piano_pkg::SONG_LEN));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            step       <= '0;
            look.valid <= 1'b0;
        end else begin
            look.valid <= cap.valid && song_left;
            if (cap.valid && song_left) begin
                step <= step + 1'b1;
            end
        end
    end

    // Payload follows the press, table read only matters while steps remain
    always_ff @(posedge clock) begin
        look.key     <= cap.key;
        look.elapsed <= cap.elapsed;
        look.step    <= step;
        if (song_left) begin
            look.expected <= piano_pkg::SONG_NOTES[step];
            look.duration <= piano_pkg::SONG_BEATS[step];
        end
    end

endmodule

`default_nettype wire

//--- source/beat_timer.sv
// Metronome beat pulse and saturating count of beats since the last accepted key
`timescale 1ns/100ps
`default_nettype none

module beat_timer (
    input  wire logic  clock,
    input  wire logic  rst_n,
    input  wire logic  beat_clear,
    output logic       beat,
    output logic [3:0] elapsed
);

    logic [piano_pkg::BEAT_W-1:0] cycle_cnt;
    logic                         last_cycle;

    assign last_cycle = (cycle_cnt == piano_pkg::BEAT_W'(piano_pkg::BEAT_CYCLES - 1));

    // Free running cycle counter, wraps every beat
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (last_cycle) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // One cycle pulse per beat
    assign beat = last_cycle;

    // Clear wins over a beat in the same cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            elapsed <= 4'd0;
        end else if (beat_clear) begin
            elapsed <= 4'd0;
        end else if (beat && (elapsed != piano_pkg::ELAPSED_MAX)) begin
            elapsed <= elapsed + 4'd1;
        end
    end

endmodule

`default_nettype wire

//--- source/key_capture.sv
// Key entry stage with four-phase req/ack FSM and pressed note register
`timescale 1ns/100ps
`default_nettype none

module key_capture (
    input  wire logic              clock,
    input  wire logic              rst_n,
    input  wire logic              key_req,
    input  wire piano_pkg::note_t  key,
    input  wire logic [3:0]        elapsed,
    output logic                   key_ack,
    output logic                   beat_clear,
    output piano_pkg::capture_s    cap
);

    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } ack_state_e;

    ack_state_e        state;
    logic              req_q;
    piano_pkg::note_t  key_q;
    logic              accept;

    // Request and key are sampled together, key is held stable by the sender
    always_ff @(posedge clock) begin
        key_q <= key;
    end

    // First cycle of a request seen in idle
    assign accept = (state == ST_IDLE) && req_q;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            req_q <= 1'b0;
            state <= ST_IDLE;
        end else begin
            req_q <= key_req;
            case (state)
                ST_IDLE: begin
                    if (req_q) begin
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    // Hold ack until the request is seen low
                    if (!req_q) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign key_ack = (state == ST_ACK);

    // A zero key is acknowledged but does not make an item
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cap.valid  <= 1'b0;
            beat_clear <= 1'b0;
        end else begin
            cap.valid  <= accept && (key_q != '0);
            beat_clear <= accept && (key_q != '0);
        end
    end

    always_ff @(posedge clock) begin
        cap.key     <= key_q;
        cap.elapsed <= elapsed;
    end

endmodule

`default_nettype wire

//--- source/piano_pkg.sv
// Shared note and step types, timing constants, song tables and pipeline stage structs
`default_nettype none

package piano_pkg;

    // Note code, 0 is no key and 1 to 12 are the notes
    typedef logic [3:0] note_t;

    // Index into the song tables
    typedef logic [3:0] step_t;

    localparam int NUM_LEDS        = 12;
    localparam int BEAT_CYCLES     = 16;
    localparam int FEEDBACK_CYCLES = 24;
    localparam int SONG_LEN        = 12;

    // Counter widths derived from the timing constants
    localparam int BEAT_W     = $clog2(BEAT_CYCLES);
    localparam int FEEDBACK_W = $clog2(FEEDBACK_CYCLES + 1);

    // Elapsed beat count saturates here
    localparam logic [3:0] ELAPSED_MAX = 4'd15;

    // Song melody, one note per step
    localparam note_t SONG_NOTES [SONG_LEN] = '{
        4'd1, 4'd3, 4'd5, 4'd6, 4'd8, 4'd10,
        4'd12, 4'd10, 4'd8, 4'd6, 4'd5, 4'd1
    };

    // Beats expected between the previous press and this one
    // Entry 0 is counted from the end of reset
    localparam logic [3:0] SONG_BEATS [SONG_LEN] = '{
        4'd1, 4'd2, 4'd1, 4'd2, 4'd4, 4'd1,
        4'd3, 4'd2, 4'd1, 4'd2, 4'd3, 4'd4
    };

    // Capture stage output
    typedef struct packed {
        logic       valid;
        note_t      key;
        logic [3:0] elapsed;
    } capture_s;

    // Lookup stage output, the captured press plus the song entry it is checked against
    typedef struct packed {
        logic       valid;
        note_t      key;
        logic [3:0] elapsed;
        step_t      step;
        note_t      expected;
        logic [3:0] duration;
    } lookup_s;

    // Judged press
    typedef struct packed {
        logic  valid;
        step_t step;
        note_t key;
        logic  note_ok;
        logic  timing_ok;
    } result_s;

endpackage

`default_nettype wire
